// ==== Bender.yml ====
package:
  name: prbs_link

export_include_dirs:
  - include

sources:
  # Packages first, then leaf modules, then the top level
  - include_dirs:
      - include
    files:
      - rtl/prbs_pkg.sv
      - rtl/link_pkg.sv
      - rtl/prbs_gen.sv
      - rtl/lane_delay_line.sv
      - rtl/prbs_checker.sv
      - rtl/link_bucket_counter.sv
      - rtl/link_fsm.sv
      - rtl/prbs_link_top.sv

  # Testbench, top module tb_prbs_link
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_prbs_link.sv

// ==== flist.f ====
+incdir+include
rtl/prbs_pkg.sv
rtl/link_pkg.sv
rtl/prbs_gen.sv
rtl/lane_delay_line.sv
rtl/prbs_checker.sv
rtl/link_bucket_counter.sv
rtl/link_fsm.sv
rtl/prbs_link_top.sv
sim/tb_prbs_link.sv

// ==== include/prbs_link_params.svh ====
`ifndef PRBS_LINK_PARAMS_SVH
`define PRBS_LINK_PARAMS_SVH

//--------------------------------------------------------------------
// PRBS pattern
//--------------------------------------------------------------------

// PRBS-7, x^7 + x^6 + 1
`define PRBS_POLY_LEN 7
// Second feedback tap
`define PRBS_POLY_TAP 6
// Bits produced per fabric cycle
`define PRBS_WORD_W 8

//--------------------------------------------------------------------
// Lane fan-out
//--------------------------------------------------------------------

// One lane per loopback channel
`define N_LANES 28

//--------------------------------------------------------------------
// Leaky-bucket link counter
//--------------------------------------------------------------------

`define LINK_CTR_W 7
// Link rises here, counter saturates here
`define LINK_CTR_MAX 67
// Penalty per cycle with any lane mismatch
`define LINK_CTR_DROP 34

`endif

// ==== rtl/lane_delay_line.sv ====
`timescale 1ns/1ps
`include "prbs_link_params.svh"

module lane_delay_line (
   input  logic                  clkout1,
   input  logic                  link_down_latched_reset_sync,
   input  prbs_pkg::lane_word_t  i_word,
   output prbs_pkg::lane_bus_t   o_lanes
);

   // Stage k drives lane k with a lag of k+1 cycles behind the generator
   logic [`N_LANES-1:0]                      valid_q;
   logic [`N_LANES-1:0][`PRBS_WORD_W-1:0]    data_q;

   // Cleared valid chain keeps stale words away from the checkers
   always_ff @(posedge clkout1) begin
      if (link_down_latched_reset_sync) begin
         valid_q <= '0;
      end else begin
         valid_q <= {valid_q[`N_LANES-2:0], i_word.valid};
      end
   end

   // Payload shifts one stage per cycle
   always_ff @(posedge clkout1) begin
      if (link_down_latched_reset_sync) begin
         data_q <= '0;
      end else begin
         data_q <= {data_q[`N_LANES-2:0], i_word.data};
      end
   end

   //--------------------------------------------------------------------
   // Lane outputs
   //--------------------------------------------------------------------

   for (genvar k = 0; k < `N_LANES; k++) begin : g_lane
      assign o_lanes[k] = '{valid: valid_q[k], data: data_q[k]};
   end

endmodule

// ==== rtl/link_bucket_counter.sv ====
`timescale 1ns/1ps
`include "prbs_link_params.svh"

module link_bucket_counter (
   input  logic                   clkout1,
   input  logic                   link_down_latched_reset_sync,
   input  link_pkg::bucket_cmd_t  i_cmd,
   output logic                   o_at_max,
   output logic                   o_drop_empties
);

   localparam logic [`LINK_CTR_W-1:0] CTR_MAX  = `LINK_CTR_W'(`LINK_CTR_MAX);
   localparam logic [`LINK_CTR_W-1:0] CTR_DROP = `LINK_CTR_W'(`LINK_CTR_DROP);

   logic [`LINK_CTR_W-1:0] count_q;

   //--------------------------------------------------------------------
   // Command execution
   //--------------------------------------------------------------------

   always_ff @(posedge clkout1) begin
      if (link_down_latched_reset_sync) begin
         count_q <= '0;
      end else begin
         case (i_cmd)
            link_pkg::BKT_CLEAR: count_q <= '0;
            // Saturate at the link-up threshold
            link_pkg::BKT_INC: begin
               if (count_q < CTR_MAX) begin
                  count_q <= count_q + 1'b1;
               end
            end
            // Floor at zero, no wrap
            link_pkg::BKT_DROP: begin
               if (count_q > CTR_DROP) begin
                  count_q <= count_q - CTR_DROP;
               end else begin
                  count_q <= '0;
               end
            end
            default: count_q <= count_q;
         endcase
      end
   end

   //--------------------------------------------------------------------
   // Threshold flags
   //--------------------------------------------------------------------

   assign o_at_max       = (count_q == CTR_MAX);
   // Next drop would empty the bucket
   assign o_drop_empties = (count_q <= CTR_DROP);

endmodule

// ==== rtl/link_fsm.sv ====
`timescale 1ns/1ps
`include "prbs_link_params.svh"

module link_fsm (
   input  logic                    clkout1,
   input  logic                    link_down_latched_reset_sync,
   input  logic [`N_LANES-1:0]     i_lane_match,
   input  logic                    i_at_max,
   input  logic                    i_drop_empties,
   output link_pkg::bucket_cmd_t   o_cmd,
   output link_pkg::link_status_t  o_status
);

   link_pkg::link_state_t state_q;
   link_pkg::link_state_t state_d;
   // Any lane failed its PRBS compare this cycle
   logic                  any_err;
   logic                  latched_q;

   assign any_err = ~(&i_lane_match);

   //--------------------------------------------------------------------
   // Leaky-bucket decision
   //--------------------------------------------------------------------

   always_comb begin
      state_d = state_q;
      o_cmd   = link_pkg::BKT_HOLD;
      case (state_q)
         // Down: need LINK_CTR_MAX clean cycles in a row
         link_pkg::LINK_DOWN: begin
            if (any_err) begin
               o_cmd = link_pkg::BKT_CLEAR;
            end else if (!i_at_max) begin
               o_cmd = link_pkg::BKT_INC;
            end else begin
               state_d = link_pkg::LINK_UP;
            end
         end
         // Up: errors cost LINK_CTR_DROP, clean cycles earn 1 back
         link_pkg::LINK_UP: begin
            if (any_err) begin
               o_cmd = link_pkg::BKT_DROP;
               // Bucket runs dry on this drop
               if (i_drop_empties) begin
                  state_d = link_pkg::LINK_DOWN;
               end
            end else begin
               o_cmd = link_pkg::BKT_INC;
            end
         end
      endcase
   end

   //--------------------------------------------------------------------
   // State and sticky link-down flag
   //--------------------------------------------------------------------

   always_ff @(posedge clkout1) begin
      if (link_down_latched_reset_sync) begin
         state_q   <= link_pkg::LINK_DOWN;
         latched_q <= 1'b0;
      end else begin
         state_q <= state_d;
         // Set on any down cycle, so also right after reset
         if (state_q == link_pkg::LINK_DOWN) begin
            latched_q <= 1'b1;
         end
      end
   end

   assign o_status = '{link_up: (state_q == link_pkg::LINK_UP), link_down_latched: latched_q};

endmodule

// ==== rtl/link_pkg.sv ====
package link_pkg;

   //-----------------------------------------------------------------
   // Link state machine
   //-----------------------------------------------------------------

   // Two-state link indication, matches the status bit encoding
   typedef enum logic [0:0] {
      LINK_DOWN = 1'b0,
      LINK_UP   = 1'b1
   } link_state_t;

   //-----------------------------------------------------------------
   // Bucket counter commands
   //-----------------------------------------------------------------

   // Hold, clear to zero, +1 saturating, -DROP floored at zero
   typedef enum logic [1:0] {
      BKT_HOLD  = 2'd0,
      BKT_CLEAR = 2'd1,
      BKT_INC   = 2'd2,
      BKT_DROP  = 2'd3
   } bucket_cmd_t;

   //-----------------------------------------------------------------
   // Status seen at the top level
   //-----------------------------------------------------------------

   typedef struct packed {
      logic link_up;
      // Sticky, set by any link-down cycle since reset
      logic link_down_latched;
   } link_status_t;

endpackage

// ==== rtl/prbs_checker.sv ====
`timescale 1ns/1ps

module prbs_checker (
   input  logic                  clkout1,
   input  logic                  link_down_latched_reset_sync,
   input  prbs_pkg::lane_word_t  i_rx,
   output logic                  o_match
);

   // Previous rx beat used as the LFSR seed
   logic                  prev_valid;
   prbs_pkg::prbs_word_t  prev_data;
   // Expected current word
   prbs_pkg::prbs_word_t  predicted;
   logic                  match_q;

   //--------------------------------------------------------------------
   // Prediction
   //--------------------------------------------------------------------

   // Self-synchronizing seed taken from the received stream itself
   // A bad word therefore fails itself and the word after it
   assign predicted = prbs_pkg::prbs_next_word(prbs_pkg::prbs_tail_state(prev_data));

   always_ff @(posedge clkout1) begin
      if (link_down_latched_reset_sync) begin
         prev_valid <= 1'b0;
         match_q    <= 1'b1;
      end else begin
         prev_valid <= i_rx.valid;
         // Nothing to compare until two valid words in a row
         if (i_rx.valid && prev_valid) begin
            match_q <= (predicted == i_rx.data);
         end else begin
            match_q <= 1'b1;
         end
      end
   end

   // Last rx data seeds the next prediction
   always_ff @(posedge clkout1) begin
      if (link_down_latched_reset_sync) begin
         prev_data <= '0;
      end else begin
         prev_data <= i_rx.data;
      end
   end

   // One cycle behind the rx word
   assign o_match = match_q;

endmodule

// ==== rtl/prbs_gen.sv ====
`timescale 1ns/1ps
`include "prbs_link_params.svh"

module prbs_gen (
   input  logic                   clkout1,
   input  logic                   link_down_latched_reset_sync,
   input  logic                   i_force_error,
   output prbs_pkg::lane_word_t   o_word
);

   // LFSR state seeded with all ones
   prbs_pkg::prbs_state_t state_q;
   // Delayed force input for edge detect
   logic                  force_dly;
   logic                  inject;
   logic                  valid_q;
   prbs_pkg::prbs_word_t  clean_word;
   prbs_pkg::prbs_word_t  data_q;

   //--------------------------------------------------------------------
   // Word generation
   //--------------------------------------------------------------------

   // Next 8 bits of the pattern from the current state
   assign clean_word = prbs_pkg::prbs_next_word(state_q);

   // Single-cycle pulse on the rising edge of the force input
   assign inject = i_force_error & ~force_dly;

   always_ff @(posedge clkout1) begin
      if (link_down_latched_reset_sync) begin
         state_q   <= '1;
         force_dly <= 1'b0;
         valid_q   <= 1'b0;
      end else begin
         // State follows the clean word so an injected error hits one word only
         state_q   <= prbs_pkg::prbs_tail_state(clean_word);
         force_dly <= i_force_error;
         valid_q   <= 1'b1;
      end
   end

   // Error flips bit 0 of the outgoing word
   always_ff @(posedge clkout1) begin
      if (link_down_latched_reset_sync) begin
         data_q <= '0;
      end else begin
         data_q <= clean_word ^ {{(`PRBS_WORD_W-1){1'b0}}, inject};
      end
   end

   //--------------------------------------------------------------------
   // Output beat
   //--------------------------------------------------------------------

   assign o_word = '{valid: valid_q, data: data_q};

endmodule

// ==== rtl/prbs_link_top.sv ====
`timescale 1ns/1ps
`include "prbs_link_params.svh"

module prbs_link_top (
   input  logic                    clkout1,
   input  logic                    link_down_latched_reset_sync,
   input  logic                    i_force_error,
   output prbs_pkg::lane_bus_t     o_tx_lanes,
   input  prbs_pkg::lane_bus_t     i_rx_lanes,
   output link_pkg::link_status_t  o_status
);

   // Generator output before fan-out
   prbs_pkg::lane_word_t   gen_word;
   // Per-lane compare result, 1 means clean
   logic [`N_LANES-1:0]    lane_match;
   link_pkg::bucket_cmd_t  bucket_cmd;
   logic                   at_max;
   logic                   drop_empties;

   //--------------------------------------------------------------------
   // Transmit side
   //--------------------------------------------------------------------

   prbs_gen prbs_gen_inst (
      .clkout1                      (clkout1),
      .link_down_latched_reset_sync (link_down_latched_reset_sync),
      .i_force_error                (i_force_error),
      .o_word                       (gen_word)
   );

   // Lane k lags the generator by k+1 cycles
   lane_delay_line lane_delay_line_inst (
      .clkout1                      (clkout1),
      .link_down_latched_reset_sync (link_down_latched_reset_sync),
      .i_word                       (gen_word),
      .o_lanes                      (o_tx_lanes)
   );

   //--------------------------------------------------------------------
   // Receive side, one checker per looped-back lane
   //--------------------------------------------------------------------

   for (genvar g = 0; g < `N_LANES; g++) begin : g_chk
      prbs_checker prbs_checker_inst (
         .clkout1                      (clkout1),
         .link_down_latched_reset_sync (link_down_latched_reset_sync),
         .i_rx                         (i_rx_lanes[g]),
         .o_match                      (lane_match[g])
      );
   end

   //--------------------------------------------------------------------
   // Link management
   //--------------------------------------------------------------------

   link_bucket_counter link_bucket_counter_inst (
      .clkout1                      (clkout1),
      .link_down_latched_reset_sync (link_down_latched_reset_sync),
      .i_cmd                        (bucket_cmd),
      .o_at_max                     (at_max),
      .o_drop_empties               (drop_empties)
   );

   // Acts on the raw match vector, no extra pipeline stage
   link_fsm link_fsm_inst (
      .clkout1                      (clkout1),
      .link_down_latched_reset_sync (link_down_latched_reset_sync),
      .i_lane_match                 (lane_match),
      .i_at_max                     (at_max),
      .i_drop_empties               (drop_empties),
      .o_cmd                        (bucket_cmd),
      .o_status                     (o_status)
   );

endmodule

// ==== rtl/prbs_pkg.sv ====
`include "prbs_link_params.svh"

package prbs_pkg;

   // Raw PRBS word and the LFSR state behind it
   typedef logic [`PRBS_WORD_W-1:0] prbs_word_t;
   typedef logic [`PRBS_POLY_LEN-1:0] prbs_state_t;

   // One lane beat, valid goes high with the first word after reset
   typedef struct packed {
      logic       valid;
      prbs_word_t data;
   } lane_word_t;

   // All lanes side by side, lane 0 in the low bits
   typedef lane_word_t [`N_LANES-1:0] lane_bus_t;

   // Run the LFSR one word ahead; bit 0 is the oldest bit on the wire
   function automatic prbs_word_t prbs_next_word(input prbs_state_t state);
      prbs_state_t lfsr;
      prbs_word_t  word;
      logic        fb;
      int          i;
      lfsr = state;
      for (i = 0; i < `PRBS_WORD_W; i++) begin
         fb      = lfsr[`PRBS_POLY_TAP-1] ^ lfsr[`PRBS_POLY_LEN-1];
         word[i] = fb;
         // Newest bit enters at the LSB
         lfsr    = {lfsr[`PRBS_POLY_LEN-2:0], fb};
      end
      return word;
   endfunction

   // LFSR state left behind by a word, i.e. its last POLY_LEN bits reversed
   function automatic prbs_state_t prbs_tail_state(input prbs_word_t word);
      prbs_state_t state;
      int          i;
      for (i = 0; i < `PRBS_POLY_LEN; i++) begin
         state[i] = word[`PRBS_WORD_W-1-i];
      end
      return state;
   endfunction

endpackage

// ==== sim/tb_prbs_link.sv ====
`timescale 1ns/1ps
`include "prbs_link_params.svh"

module tb_prbs_link;

   localparam logic [7:0] NO_LANE = 8'hFF;
   // Force input held high for several cycles to exercise the edge detect
   localparam int FORCE_HOLD = 4;

   // One stimulus row with the status expected at its last cycle
   typedef struct packed {
      logic [15:0] cycles;
      logic        do_reset;
      logic        force_pulse;
      logic [7:0]  lane;
      logic        exp_up;
      logic        exp_latched;
   } row_t;

   logic                   clkout1;
   logic                   link_down_latched_reset_sync;
   logic                   i_force_error;
   prbs_pkg::lane_bus_t    tx_lanes;
   prbs_pkg::lane_bus_t    rx_lanes;
   // Per-lane corruption applied on the loopback path
   prbs_pkg::lane_bus_t    rx_mask;
   link_pkg::link_status_t status;

   row_t table_rows [0:7];
   int   timeout_limit;
   int   cycle_cnt = 0;
   int   fail_count = 0;

   // Inputs seen by the DUT in the current cycle
   logic       cur_rst;
   logic       cur_force;
   logic [7:0] cur_lane;
   logic [7:0] cur_mask;

   //----------------------------------------------------------------------
   // Reference model state as visible in the current cycle
   //----------------------------------------------------------------------

   logic [`PRBS_WORD_W-1:0] m_gen_prev;
   logic                    m_gen_valid;
   logic [`PRBS_WORD_W-1:0] m_gen_data;
   logic                    m_force_prev;
   logic                    m_lane_valid [`N_LANES];
   logic [`PRBS_WORD_W-1:0] m_lane_data [`N_LANES];
   logic                    m_chk_pv [`N_LANES];
   logic [`PRBS_WORD_W-1:0] m_chk_pd [`N_LANES];
   logic                    m_match [`N_LANES];
   logic                    m_up;
   int                      m_cnt;
   logic                    m_latched;

   prbs_link_top dut0 (
      .clkout1                      (clkout1),
      .link_down_latched_reset_sync (link_down_latched_reset_sync),
      .i_force_error                (i_force_error),
      .o_tx_lanes                   (tx_lanes),
      .i_rx_lanes                   (rx_lanes),
      .o_status                     (status)
   );

   // Loopback with optional corruption of the data bits only
   assign rx_lanes = tx_lanes ^ rx_mask;

   initial begin
      clkout1 = 1'b0;
      forever #10 clkout1 = ~clkout1;
   end

   // Watchdog on total run length
   always @(posedge clkout1) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt > timeout_limit) begin
         $display("Run timed out after %0d clock cycles", cycle_cnt);
         $display("Test FAILED");
         $fatal(1, "timeout");
      end
   end

   //----------------------------------------------------------------------
   // Helpers
   //----------------------------------------------------------------------

   task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp) begin
         fail_count = fail_count + 1;
         $display("** Error at time %0t: %s expected %0h, got %0h", $time, name, exp, act);
         $display("Test FAILED");
         $fatal(1, "stopping at first mismatch");
      end
   endtask

   // Serial PRBS-7 rule x[n] = x[n-6] ^ x[n-7] gives the 8 bits after a word
   function automatic logic [`PRBS_WORD_W-1:0] extend_sequence(
      input logic [`PRBS_WORD_W-1:0] prev);
      logic [2*`PRBS_WORD_W-1:0] seq;
      int                        j;
      seq = {{`PRBS_WORD_W{1'b0}}, prev};
      for (j = `PRBS_WORD_W; j < 2*`PRBS_WORD_W; j++) begin
         seq[j] = seq[j-`PRBS_POLY_TAP] ^ seq[j-`PRBS_POLY_LEN];
      end
      return seq[2*`PRBS_WORD_W-1:`PRBS_WORD_W];
   endfunction

   // Advance the model by one clock edge using the inputs of the ending cycle
   task automatic model_step();
      logic [`PRBS_WORD_W-1:0] clean;
      logic [`PRBS_WORD_W-1:0] rx_d;
      logic                    any_err;
      int                      k;
      if (cur_rst) begin
         // All-ones seed as an 8-bit history of ones
         m_gen_prev   = '1;
         m_gen_valid  = 1'b0;
         m_force_prev = 1'b0;
         for (k = 0; k < `N_LANES; k++) begin
            m_lane_valid[k] = 1'b0;
            m_chk_pv[k]     = 1'b0;
            m_match[k]      = 1'b1;
         end
         m_up      = 1'b0;
         m_cnt     = 0;
         m_latched = 1'b0;
      end else begin
         any_err = 1'b0;
         for (k = 0; k < `N_LANES; k++) begin
            if (!m_match[k]) begin
               any_err = 1'b1;
            end
         end
         // Latch looks at the state before this edge
         if (!m_up) begin
            m_latched = 1'b1;
         end
         // Leaky bucket
         if (!m_up) begin
            if (any_err) begin
               m_cnt = 0;
            end else if (m_cnt < `LINK_CTR_MAX) begin
               m_cnt = m_cnt + 1;
            end else begin
               m_up = 1'b1;
            end
         end else begin
            if (any_err) begin
               if (m_cnt <= `LINK_CTR_DROP) begin
                  m_up = 1'b0;
               end
               m_cnt = (m_cnt > `LINK_CTR_DROP) ? m_cnt - `LINK_CTR_DROP : 0;
            end else if (m_cnt < `LINK_CTR_MAX) begin
               m_cnt = m_cnt + 1;
            end
         end
         // Checkers see tx xor mask and predict from the last rx word
         for (k = 0; k < `N_LANES; k++) begin
            rx_d = m_lane_data[k] ^ ((k == cur_lane) ? cur_mask : '0);
            if (m_lane_valid[k] && m_chk_pv[k]) begin
               m_match[k] = (extend_sequence(m_chk_pd[k]) == rx_d);
            end else begin
               m_match[k] = 1'b1;
            end
            m_chk_pv[k] = m_lane_valid[k];
            m_chk_pd[k] = rx_d;
         end
         // Delay line shift makes lane k lag lane 0 by k cycles
         for (k = `N_LANES-1; k > 0; k--) begin
            m_lane_valid[k] = m_lane_valid[k-1];
            m_lane_data[k]  = m_lane_data[k-1];
         end
         m_lane_valid[0] = m_gen_valid;
         m_lane_data[0]  = m_gen_data;
         // A rising force edge flips bit 0 of the next generated word
         clean        = extend_sequence(m_gen_prev);
         m_gen_data   = clean ^ {{(`PRBS_WORD_W-1){1'b0}}, cur_force & ~m_force_prev};
         m_gen_valid  = 1'b1;
         m_gen_prev   = clean;
         m_force_prev = cur_force;
      end
   endtask

   task automatic compare_outputs();
      int k;
      for (k = 0; k < `N_LANES; k++) begin
         check_val($sformatf("o_tx_lanes[%0d].valid", k), m_lane_valid[k], tx_lanes[k].valid);
         if (m_lane_valid[k]) begin
            check_val($sformatf("o_tx_lanes[%0d].data", k), m_lane_data[k], tx_lanes[k].data);
         end
      end
      check_val("o_status.link_up", m_up, status.link_up);
      check_val("o_status.link_down_latched", m_latched, status.link_down_latched);
   endtask

   // Each clock updates the model and drives new inputs before the falling-edge check
   task automatic run_cycle(input logic rst, input logic frc, input logic [7:0] lane,
                            input logic [7:0] mask);
      prbs_pkg::lane_bus_t m;
      @(posedge clkout1);
      model_step();
      cur_rst   = rst;
      cur_force = frc;
      cur_lane  = lane;
      cur_mask  = mask;
      m = '0;
      if (lane < `N_LANES) begin
         m[lane].data = mask;
      end
      link_down_latched_reset_sync <= rst;
      i_force_error                <= frc;
      rx_mask                      <= m;
      @(negedge clkout1);
      compare_outputs();
   endtask

   task automatic apply_row(input row_t row);
      logic [7:0] mask;
      int         n;
      mask = '0;
      // Bits 7..1 never all zero so the next word also fails
      if (row.lane != NO_LANE) begin
         mask = 8'((($urandom % 127) + 1) * 2 + ($urandom % 2));
      end
      for (n = 0; n < int'(row.cycles); n++) begin
         if (n == 0) begin
            run_cycle(row.do_reset, row.force_pulse, row.lane, mask);
         end else begin
            run_cycle(row.do_reset, row.force_pulse && (n < FORCE_HOLD), NO_LANE, 8'h00);
         end
      end
      check_val("o_status.link_up at row end", row.exp_up, status.link_up);
      check_val("o_status.link_down_latched at row end", row.exp_latched,
                status.link_down_latched);
   endtask

   //----------------------------------------------------------------------
   // Stimulus table and main sequence
   //----------------------------------------------------------------------

   initial begin
      int r;
      void'($urandom(61539));
      // Reset level set at time zero adds the third reset cycle
      table_rows[0] = '{cycles: 16'd2,  do_reset: 1'b1, force_pulse: 1'b0, lane: NO_LANE,
                        exp_up: 1'b0, exp_latched: 1'b0};
      // Clean link rises after LINK_CTR_MAX good cycles
      table_rows[1] = '{cycles: 16'd80, do_reset: 1'b0, force_pulse: 1'b0, lane: NO_LANE,
                        exp_up: 1'b1, exp_latched: 1'b1};
      // Injected word walking across all lanes drains the bucket
      table_rows[2] = '{cycles: 16'd60, do_reset: 1'b0, force_pulse: 1'b1, lane: NO_LANE,
                        exp_up: 1'b0, exp_latched: 1'b1};
      table_rows[3] = '{cycles: 16'd60, do_reset: 1'b0, force_pulse: 1'b0, lane: NO_LANE,
                        exp_up: 1'b1, exp_latched: 1'b1};
      // Two mismatch cycles on one lane drop the link
      table_rows[4] = '{cycles: 16'd30, do_reset: 1'b0, force_pulse: 1'b0, lane: 8'd13,
                        exp_up: 1'b0, exp_latched: 1'b1};
      table_rows[5] = '{cycles: 16'd50, do_reset: 1'b0, force_pulse: 1'b0, lane: NO_LANE,
                        exp_up: 1'b1, exp_latched: 1'b1};
      // Only a reset clears the sticky flag
      table_rows[6] = '{cycles: 16'd3,  do_reset: 1'b1, force_pulse: 1'b0, lane: NO_LANE,
                        exp_up: 1'b0, exp_latched: 1'b0};
      table_rows[7] = '{cycles: 16'd80, do_reset: 1'b0, force_pulse: 1'b0, lane: NO_LANE,
                        exp_up: 1'b1, exp_latched: 1'b1};
      timeout_limit = 100;
      for (r = 0; r < 8; r++) begin
         timeout_limit = timeout_limit + int'(table_rows[r].cycles);
      end
      link_down_latched_reset_sync = 1'b1;
      i_force_error                = 1'b0;
      rx_mask                      = '0;
      cur_rst   = 1'b1;
      cur_force = 1'b0;
      cur_lane  = NO_LANE;
      cur_mask  = 8'h00;
      for (r = 0; r < 8; r++) begin
         apply_row(table_rows[r]);
      end
      if (fail_count == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule
